//--- Makefile
TOP = mem_subsys_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir

//--- rtl/bus_ctrl_fsm.sv
`timescale 1ns/1ns

module bus_ctrl_fsm (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                fetch_pending,
    input  logic                lsu_pending,
    input  mem_pkg::target_t    target,
    input  logic                write,
    input  mem_pkg::axi_rsp_t   bus_rsp,
    output mem_pkg::owner_t     owner,
    output mem_pkg::bus_ctrl_t  bus_ctrl
);

    mem_pkg::bus_state_t state;
    mem_pkg::bus_state_t state_next;
    mem_pkg::owner_t     owner_q;
    mem_pkg::owner_t     pick;
    logic                aw_done;
    logic                w_done;
    logic                aw_ok;
    logic                w_ok;

    assign pick  = lsu_pending ? mem_pkg::own_lsu : mem_pkg::own_fetch; // load/store wins a tie.
    assign owner = (state == mem_pkg::st_idle) ? pick : owner_q;

    assign aw_ok = aw_done || bus_rsp.awready;
    assign w_ok  = w_done || bus_rsp.wready;

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::st_idle: begin
                if (fetch_pending || lsu_pending) begin
                    case (target)
                        mem_pkg::tgt_mem:   state_next = write ? mem_pkg::st_aw_w : mem_pkg::st_ar;
                        mem_pkg::tgt_clint: state_next = mem_pkg::st_local;
                        default:            state_next = mem_pkg::st_resp;
                    endcase
                end
            end
            mem_pkg::st_ar: begin
                if (bus_rsp.arready) begin
                    state_next = mem_pkg::st_r;
                end
            end
            mem_pkg::st_r: begin
                if (bus_rsp.rvalid) begin
                    state_next = mem_pkg::st_resp;
                end
            end
            mem_pkg::st_aw_w: begin
                if (aw_ok && w_ok) begin
                    state_next = mem_pkg::st_b;
                end
            end
            mem_pkg::st_b: begin
                if (bus_rsp.bvalid) begin
                    state_next = mem_pkg::st_resp;
                end
            end
            mem_pkg::st_local: state_next = mem_pkg::st_resp; // timer word lands next cycle.
            default:           state_next = mem_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mem_pkg::st_idle;
            owner_q <= mem_pkg::own_fetch;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;
            if (state == mem_pkg::st_idle) begin
                owner_q <= pick;
            end
            if (state == mem_pkg::st_aw_w && !(aw_ok && w_ok)) begin
                aw_done <= aw_ok; // remember the half that was already taken.
                w_done  <= w_ok;
            end else begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    always_comb begin
        bus_ctrl = '0;
        case (state)
            mem_pkg::st_ar:    bus_ctrl.arvalid = 1'b1;
            mem_pkg::st_r:     bus_ctrl.rready = 1'b1;
            mem_pkg::st_aw_w: begin
                bus_ctrl.awvalid = !aw_done;
                bus_ctrl.wvalid  = !w_done;
            end
            mem_pkg::st_b:     bus_ctrl.bready = 1'b1;
            mem_pkg::st_local: bus_ctrl.timer_rd = 1'b1;
            mem_pkg::st_resp:  bus_ctrl.rsp_valid = 1'b1;
            default:           bus_ctrl = '0;
        endcase
    end

endmodule

//--- rtl/clint_timer.sv
`timescale 1ns/1ns

module clint_timer (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        rd,
    input  logic        rd_hi,
    output logic [31:0] rdata
);

    logic [63:0] mtime;

    // free-running machine timer.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (rd) begin
            rdata <= rd_hi ? mtime[63:32] : mtime[31:0]; // valid the cycle after the strobe.
        end
    end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

    // address map of the subsystem.
    localparam logic [31:0] clint_base = 32'h0200_0000;
    localparam logic [31:0] clint_mask = 32'h0000_ffff;  // 64 KiB timer window.
    localparam logic [31:0] mem_base   = 32'h8000_0000;
    localparam logic [31:0] mem_mask   = 32'h0fff_ffff;  // 256 MiB of external memory.

    localparam logic [31:0] mtime_lo_off = 32'h0000_bff8;
    localparam logic [31:0] mtime_hi_off = 32'h0000_bffc;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        logic        err;
    } mem_rsp_t;

    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        rready;
        logic        bready;
    } axi_req_t;

    typedef struct packed {
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
    } axi_rsp_t;

    typedef enum logic [1:0] {tgt_mem, tgt_clint, tgt_fault} target_t;

    typedef enum logic {own_fetch, own_lsu} owner_t;

    typedef enum logic [2:0] {st_idle, st_ar, st_r, st_aw_w, st_b, st_local, st_resp} bus_state_t;

    typedef struct packed {
        logic arvalid;
        logic awvalid;
        logic wvalid;
        logic rready;
        logic bready;
        logic timer_rd;
        logic rsp_valid;
    } bus_ctrl_t;

endpackage

//--- rtl/mem_route.sv
`timescale 1ns/1ns

module mem_route (
    input  logic                clock,
    input  logic                rst_n,
    input  mem_pkg::mem_req_t   fetch_req,
    input  mem_pkg::mem_req_t   lsu_req,
    output mem_pkg::mem_rsp_t   fetch_rsp,
    output mem_pkg::mem_rsp_t   lsu_rsp,
    input  mem_pkg::owner_t     owner,
    input  mem_pkg::bus_ctrl_t  bus_ctrl,
    output logic                fetch_pending,
    output logic                lsu_pending,
    output mem_pkg::target_t    target,
    output logic                write,
    output mem_pkg::axi_req_t   bus_req,
    input  mem_pkg::axi_rsp_t   bus_rsp
);

    mem_pkg::mem_req_t sel;
    logic [31:0]       offset;
    logic              in_mem;
    logic              in_clint;
    logic              is_mtime_lo;
    logic              is_mtime_hi;
    logic [31:0]       timer_rdata;
    logic              fetch_valid_q;
    logic              lsu_valid_q;
    logic [31:0]       rdata_q;
    logic [1:0]        resp_q;

    assign sel   = (owner == mem_pkg::own_lsu) ? lsu_req : fetch_req;
    assign write = sel.write;

    assign offset      = sel.addr & mem_pkg::clint_mask;
    assign in_mem      = (sel.addr & ~mem_pkg::mem_mask) == mem_pkg::mem_base;
    assign in_clint    = (sel.addr & ~mem_pkg::clint_mask) == mem_pkg::clint_base;
    assign is_mtime_lo = offset == mem_pkg::mtime_lo_off;
    assign is_mtime_hi = offset == mem_pkg::mtime_hi_off;

    // the timer is read-only, so a write into its window faults.
    always_comb begin
        if (in_mem) begin
            target = mem_pkg::tgt_mem;
        end else if (in_clint && !sel.write && (is_mtime_lo || is_mtime_hi)) begin
            target = mem_pkg::tgt_clint;
        end else begin
            target = mem_pkg::tgt_fault;
        end
    end

    // a requester that is being answered this cycle is not pending again.
    assign fetch_pending = fetch_req.valid && !fetch_valid_q;
    assign lsu_pending   = lsu_req.valid && !lsu_valid_q;

    always_comb begin
        bus_req         = '0;
        bus_req.arvalid = bus_ctrl.arvalid;
        bus_req.araddr  = sel.addr;
        bus_req.awvalid = bus_ctrl.awvalid;
        bus_req.awaddr  = sel.addr;
        bus_req.wvalid  = bus_ctrl.wvalid;
        bus_req.wdata   = sel.wdata;
        bus_req.wstrb   = sel.wstrb;
        bus_req.rready  = bus_ctrl.rready;
        bus_req.bready  = bus_ctrl.bready;
    end

    clint_timer u_timer (
        .clock (clock           ),
        .rst_n (rst_n           ),
        .rd    (bus_ctrl.timer_rd),
        .rd_hi (is_mtime_hi     ),
        .rdata (timer_rdata     )
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid_q <= 1'b0;
            lsu_valid_q   <= 1'b0;
        end else begin
            fetch_valid_q <= bus_ctrl.rsp_valid && (owner == mem_pkg::own_fetch);
            lsu_valid_q   <= bus_ctrl.rsp_valid && (owner == mem_pkg::own_lsu);
        end
    end

    always_ff @(posedge clock) begin
        if (bus_ctrl.rready && bus_rsp.rvalid) begin
            rdata_q <= bus_rsp.rdata;
            resp_q  <= bus_rsp.rresp;
        end else if (bus_ctrl.bready && bus_rsp.bvalid) begin
            rdata_q <= '0;
            resp_q  <= bus_rsp.bresp;
        end else if (bus_ctrl.rsp_valid && target == mem_pkg::tgt_clint) begin
            rdata_q <= timer_rdata;
            resp_q  <= mem_pkg::resp_okay;
        end else if (bus_ctrl.rsp_valid && target == mem_pkg::tgt_fault) begin
            rdata_q <= '0;
            resp_q  <= mem_pkg::resp_decerr;
        end
    end

    // data and error are shared and only the valid strobe is steered.
    assign fetch_rsp = '{valid: fetch_valid_q, rdata: rdata_q, err: resp_q != mem_pkg::resp_okay};
    assign lsu_rsp   = '{valid: lsu_valid_q, rdata: rdata_q, err: resp_q != mem_pkg::resp_okay};

endmodule

//--- rtl/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic               clock,
    input  logic               rst_n,
    input  mem_pkg::mem_req_t  fetch_req,
    input  mem_pkg::mem_req_t  lsu_req,
    output mem_pkg::mem_rsp_t  fetch_rsp,
    output mem_pkg::mem_rsp_t  lsu_rsp,
    output mem_pkg::axi_req_t  bus_req,
    input  mem_pkg::axi_rsp_t  bus_rsp
);

    mem_pkg::owner_t    owner;
    mem_pkg::bus_ctrl_t bus_ctrl;
    mem_pkg::target_t   target;
    logic               fetch_pending;
    logic               lsu_pending;
    logic               write;

    bus_ctrl_fsm u_fsm (
        .clock         (clock        ),
        .rst_n         (rst_n        ),
        .fetch_pending (fetch_pending),
        .lsu_pending   (lsu_pending  ),
        .target        (target       ),
        .write         (write        ),
        .bus_rsp       (bus_rsp      ),
        .owner         (owner        ),
        .bus_ctrl      (bus_ctrl     )
    );

    mem_route u_route (
        .clock         (clock        ),
        .rst_n         (rst_n        ),
        .fetch_req     (fetch_req    ),
        .lsu_req       (lsu_req      ),
        .fetch_rsp     (fetch_rsp    ),
        .lsu_rsp       (lsu_rsp      ),
        .owner         (owner        ),
        .bus_ctrl      (bus_ctrl     ),
        .fetch_pending (fetch_pending),
        .lsu_pending   (lsu_pending  ),
        .target        (target       ),
        .write         (write        ),
        .bus_req       (bus_req      ),
        .bus_rsp       (bus_rsp      )
    );

endmodule

//--- src.f
rtl/mem_pkg.sv
rtl/clint_timer.sv
rtl/bus_ctrl_fsm.sv
rtl/mem_route.sv
rtl/mem_subsys_top.sv
test/axi_mem_model.sv
test/mem_subsys_tb.sv

//--- test/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model (
    input  logic              clock,
    input  logic              rst_n,
    input  mem_pkg::axi_req_t bus_req,
    output mem_pkg::axi_rsp_t bus_rsp
);

    logic [31:0] mem [0:1023];
    logic [31:0] lfsr;
    logic [1:0]  ar_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic        arready;
    logic        rvalid;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic        aw_got;
    logic        w_got;
    logic [31:0] rdata;
    logic [31:0] awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        d[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        d[1] = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    always @(posedge clock or negedge rst_n) begin : model_seq
        logic [1:0]  d;
        logic [31:0] word;
        if (!rst_n) begin
            lfsr = 32'h414;
            for (int i = 0; i < 1024; i++) begin
                word = 32'h8000_0000 | (i << 2);
                mem[i] = {word[15:0], ~word[15:0]}; // preset word tracks the byte address.
            end
            draw_delay(d);
            ar_wait <= d;
            draw_delay(d);
            aw_wait <= d;
            draw_delay(d);
            w_wait   <= d;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            awaddr_q <= '0;
            wdata_q  <= '0;
            wstrb_q  <= '0;
        end else begin
            if (rvalid && bus_req.rready) rvalid <= 1'b0;
            if (bus_req.arvalid && arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                rdata   <= mem[bus_req.araddr[11:2]];
                draw_delay(d);
                ar_wait <= d;
            end else if (bus_req.arvalid) begin
                if (ar_wait == 2'd0) arready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            if (bus_req.awvalid && awready) begin
                awready  <= 1'b0;
                aw_got   <= 1'b1;
                awaddr_q <= bus_req.awaddr;
                draw_delay(d);
                aw_wait <= d;
            end else if (bus_req.awvalid) begin
                if (aw_wait == 2'd0) awready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            if (bus_req.wvalid && wready) begin
                wready  <= 1'b0;
                w_got   <= 1'b1;
                wdata_q <= bus_req.wdata;
                wstrb_q <= bus_req.wstrb;
                draw_delay(d);
                w_wait <= d;
            end else if (bus_req.wvalid) begin
                if (w_wait == 2'd0) wready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            if (bvalid && bus_req.bready) bvalid <= 1'b0;
            if (aw_got && w_got) begin
                word = mem[awaddr_q[11:2]];
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_q[b]) word[8*b +: 8] = wdata_q[8*b +: 8];
                end
                mem[awaddr_q[11:2]] = word;
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

    assign bus_rsp = '{arready: arready, rvalid: rvalid, rdata: rdata,
                       rresp: mem_pkg::resp_okay, awready: awready, wready: wready,
                       bvalid: bvalid, bresp: mem_pkg::resp_okay};

endmodule

//--- test/mem_subsys_tb.sv
`timescale 1ns/1ns

module mem_subsys_tb;

    typedef enum logic [1:0] {port_fetch, port_lsu, port_both} port_t;

    typedef struct packed {
        port_t       port;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        timer;
    } row_t;

    logic              clock;
    logic              rst_n;
    mem_pkg::mem_req_t fetch_req;
    mem_pkg::mem_req_t lsu_req;
    mem_pkg::mem_rsp_t fetch_rsp;
    mem_pkg::mem_rsp_t lsu_rsp;
    mem_pkg::axi_req_t bus_req;
    mem_pkg::axi_rsp_t bus_rsp;
    row_t              stim [0:10];
    int                errors;
    int                checks;
    logic [31:0]       last_lo;

    mem_subsys_top UUT (
        .clock     (clock    ),
        .rst_n     (rst_n    ),
        .fetch_req (fetch_req),
        .lsu_req   (lsu_req  ),
        .fetch_rsp (fetch_rsp),
        .lsu_rsp   (lsu_rsp  ),
        .bus_req   (bus_req  ),
        .bus_rsp   (bus_rsp  )
    );

    axi_mem_model mem_model (
        .clock   (clock  ),
        .rst_n   (rst_n  ),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat ($size(stim) * 40 + 10) @(posedge clock);
        $display("timeout: the DUT did not answer every request in the table in time");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic load_table();
        stim[0]  = '{port_fetch, 1'b0, 32'h8000_0010, 32'h0, 4'h0, 32'h0010_ffef, 1'b0, 1'b0};
        stim[1]  = '{port_lsu, 1'b1, 32'h8000_0020, 32'haabb_ccdd, 4'b0101, 32'h0, 1'b0, 1'b0};
        stim[2]  = '{port_lsu, 1'b0, 32'h8000_0020, 32'h0, 4'h0, 32'h00bb_ffdd, 1'b0, 1'b0};
        stim[3]  = '{port_fetch, 1'b0, 32'h8000_0ffc, 32'h0, 4'h0, 32'h0ffc_f003, 1'b0, 1'b0};
        stim[4]  = '{port_both, 1'b0, 32'h8000_0100, 32'h0, 4'h0, 32'h0100_feff, 1'b0, 1'b0};
        stim[5]  = '{port_lsu, 1'b0, 32'h1000_0000, 32'h0, 4'h0, 32'h0, 1'b1, 1'b0};
        stim[6]  = '{port_lsu, 1'b1, 32'h0200_bff8, 32'hdead_beef, 4'hf, 32'h0, 1'b1, 1'b0};
        stim[7]  = '{port_lsu, 1'b0, 32'h0200_bffc, 32'h0, 4'h0, 32'h0, 1'b0, 1'b0};
        stim[8]  = '{port_fetch, 1'b0, 32'h0200_bff8, 32'h0, 4'h0, 32'h0, 1'b0, 1'b1};
        stim[9]  = '{port_lsu, 1'b0, 32'h0200_bff8, 32'h0, 4'h0, 32'h0, 1'b0, 1'b1};
        stim[10] = '{port_both, 1'b0, 32'h0200_bff8, 32'h0, 4'h0, 32'h0, 1'b0, 1'b1};
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERR @%0t ns: %s", $time, msg);
    endtask

    task automatic check_rsp(input mem_pkg::mem_rsp_t got, input mem_pkg::mem_rsp_t exp,
                             input logic cmp_data, input string what);
        checks++;
        if (got.err !== exp.err)
            report_error($sformatf("%s err %0b, expected %0b", what, got.err, exp.err));
        if (cmp_data && got.rdata !== exp.rdata)
            report_error($sformatf("%s rdata %h, expected %h", what, got.rdata, exp.rdata));
    endtask

    task automatic check_bus_idle(input mem_pkg::axi_req_t got, input string what);
        checks++;
        if ({got.arvalid, got.awvalid, got.wvalid, got.rready, got.bready} !== 5'b0)
            report_error($sformatf("%s: bus strobes %b, expected all low", what,
                         {got.arvalid, got.awvalid, got.wvalid, got.rready, got.bready}));
    endtask

    task automatic check_quiet(input string what);
        check_bus_idle(bus_req, what);
        checks++;
        if ({fetch_rsp.valid, lsu_rsp.valid} !== 2'b00)
            report_error($sformatf("%s: response strobe high", what));
    endtask

    task automatic check_answer(input mem_pkg::mem_rsp_t got, input row_t r, input string who);
        mem_pkg::mem_rsp_t exp;
        exp = '{valid: 1'b1, rdata: r.exp_rdata, err: r.exp_err};
        if (r.timer) begin
            checks++;
            if (!(got.rdata > last_lo))
                report_error($sformatf("%s mtime_lo %h not above %h", who, got.rdata, last_lo));
            last_lo = got.rdata; // the timer only counts up.
        end
        check_rsp(got, exp, !r.timer && !r.write && !r.exp_err, $sformatf("%s %h", who, r.addr));
    endtask

    task automatic run_row(input row_t r);
        logic fetch_done;
        logic lsu_done;
        logic is_mem;
        int   cycle;
        int   fetch_at;
        int   lsu_at;
        fetch_done = (r.port == port_lsu);
        lsu_done   = (r.port == port_fetch);
        is_mem     = (r.addr[31:28] == 4'h8);
        cycle      = 0;
        fetch_at   = 0;
        lsu_at     = 0;
        if (!fetch_done) begin
            fetch_req = '{valid: 1'b1, write: 1'b0, addr: r.addr, wdata: '0, wstrb: '0};
        end
        if (!lsu_done) begin
            lsu_req = '{valid: 1'b1, write: r.write, addr: r.addr, wdata: r.wdata,
                        wstrb: r.wstrb};
        end
        while (!(fetch_done && lsu_done)) begin
            @(negedge clock);
            cycle++;
            if (!is_mem) check_bus_idle(bus_req, $sformatf("local access %h", r.addr));
            if (fetch_rsp.valid === 1'b1) begin
                if (fetch_done) report_error("fetch response strobe with no fetch pending");
                else check_answer(fetch_rsp, r, "fetch");
                fetch_done = 1'b1;
                fetch_at   = cycle;
            end
            if (lsu_rsp.valid === 1'b1) begin
                if (lsu_done) report_error("lsu response strobe with no lsu request pending");
                else check_answer(lsu_rsp, r, "lsu");
                lsu_done = 1'b1;
                lsu_at   = cycle;
            end
            @(posedge clock);
            #2;
            if (fetch_done) fetch_req.valid = 1'b0;
            if (lsu_done) lsu_req.valid = 1'b0;
        end
        if (r.port == port_both) begin
            checks++;
            if (!(lsu_at < fetch_at))
                report_error($sformatf("lsu answered at %0d, fetch at %0d", lsu_at, fetch_at));
        end
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        last_lo   = '0;
        rst_n     = 1'b0;
        fetch_req = '0;
        lsu_req   = '0;
        load_table();
        @(posedge clock);
        @(negedge clock);
        check_quiet("during reset");
        @(posedge clock);
        #2;
        rst_n = 1'b1;
        @(negedge clock);
        check_quiet("after reset");
        @(posedge clock);
        #2;
        for (int i = 0; i < $size(stim); i++) begin
            run_row(stim[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
